// File: common/rd_pkg.sv
package rd_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;

    // memory geometry, indexed by addr[7:3] so reads wrap
    localparam int MEM_WORDS   = 32;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 3;                      // accept to rsp_valid, in cycles
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

    // fetch queue sizing
    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
    localparam int FQ_CNT_W = $clog2(FQ_DEPTH + 1);     // counts 0 .. FQ_DEPTH

    // access size of a read
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } rd_size_e;

    // owner of the shared read port
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_LOAD  = 2'd1,
        ARB_FETCH = 2'd2
    } arb_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        rd_size_e          size;
    } rd_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
    } rd_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        rd_size_e          size;
        logic              is_signed;    // sign-extend the result
    } load_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;           // aligned doubleword address
        logic [DATA_W-1:0] data;
    } fetch_entry_t;

endpackage

// File: arbiter/rd_arbiter.sv
`timescale 1ns/1ns

module rd_arbiter (
    input  logic            clk,
    input  logic            rst_i,

    // load side, higher priority
    input  logic            ld_req_valid_i,
    output logic            ld_req_ready_o,
    input  rd_pkg::rd_req_t ld_req_i,
    output logic            ld_rsp_valid_o,
    input  logic            ld_rsp_ready_i,
    output rd_pkg::rd_rsp_t ld_rsp_o,

    // fetch side
    input  logic            if_req_valid_i,
    output logic            if_req_ready_o,
    input  rd_pkg::rd_req_t if_req_i,
    output logic            if_rsp_valid_o,
    input  logic            if_rsp_ready_i,
    output rd_pkg::rd_rsp_t if_rsp_o,

    // shared memory port
    output logic            m_req_valid_o,
    input  logic            m_req_ready_i,
    output rd_pkg::rd_req_t m_req_o,
    input  logic            m_rsp_valid_i,
    output logic            m_rsp_ready_o,
    input  rd_pkg::rd_rsp_t m_rsp_i
);

    rd_pkg::arb_state_e state_q;
    rd_pkg::arb_state_e state_d;

    logic ld_sel;      // port owned by the load unit
    logic if_sel;      // port owned by the fetch queue
    logic rsp_fire;    // granted response taken this cycle

    assign ld_sel = (state_q == rd_pkg::ARB_LOAD);
    assign if_sel = (state_q == rd_pkg::ARB_FETCH);

    assign rsp_fire = m_rsp_valid_i && m_rsp_ready_o;

    // owner selection, one cycle in idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            rd_pkg::ARB_IDLE: begin
                if (ld_req_valid_i) begin
                    state_d = rd_pkg::ARB_LOAD;     // load wins a tie
                end else if (if_req_valid_i) begin
                    state_d = rd_pkg::ARB_FETCH;
                end
            end
            rd_pkg::ARB_LOAD,
            rd_pkg::ARB_FETCH: begin
                // grant spans request and response
                if (rsp_fire) begin
                    state_d = rd_pkg::ARB_IDLE;
                end
            end
            default: state_d = rd_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= rd_pkg::ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request steering toward memory
    assign m_req_valid_o  = (ld_sel && ld_req_valid_i) || (if_sel && if_req_valid_i);
    assign m_req_o        = ld_sel ? ld_req_i : (if_sel ? if_req_i : '0);
    assign ld_req_ready_o = ld_sel && m_req_ready_i;
    assign if_req_ready_o = if_sel && m_req_ready_i;

    // response steering back to the owner
    assign m_rsp_ready_o  = (ld_sel && ld_rsp_ready_i) || (if_sel && if_rsp_ready_i);
    assign ld_rsp_valid_o = ld_sel && m_rsp_valid_i;
    assign if_rsp_valid_o = if_sel && m_rsp_valid_i;
    assign ld_rsp_o       = ld_sel ? m_rsp_i : '0;    // loser sees zero data
    assign if_rsp_o       = if_sel ? m_rsp_i : '0;

endmodule

// File: source/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue (
    input  logic                         clk,
    input  logic                         rst_i,

    input  logic                         redirect_valid_i,  // one-cycle pulse
    input  logic [rd_pkg::ADDR_W-1:0]    redirect_pc_i,

    output logic                         req_valid_o,
    input  logic                         req_ready_i,
    output rd_pkg::rd_req_t              req_o,
    input  logic                         rsp_valid_i,
    output logic                         rsp_ready_o,
    input  rd_pkg::rd_rsp_t              rsp_i,

    output logic                         instr_valid_o,
    input  logic                         instr_ready_i,
    output rd_pkg::fetch_entry_t         instr_o
);

    rd_pkg::fetch_entry_t fifo_q [rd_pkg::FQ_DEPTH];

    logic [rd_pkg::FQ_PTR_W-1:0] wr_ptr_q;
    logic [rd_pkg::FQ_PTR_W-1:0] rd_ptr_q;
    logic [rd_pkg::FQ_CNT_W-1:0] cnt_q;
    logic [rd_pkg::FQ_CNT_W-1:0] occ;       // entries plus in-flight read

    logic [rd_pkg::ADDR_W-1:0]   pc_q;       // next doubleword to fetch
    logic [rd_pkg::ADDR_W-1:0]   req_addr_q; // address of the posted read

    logic active_q;   // set by the first redirect
    logic pend_q;     // request raised, not yet accepted
    logic wait_q;     // accepted, response pending
    logic stale_q;    // answer belongs to an old stream
    logic inflight;
    logic issue;
    logic req_fire;
    logic rsp_fire;
    logic push;
    logic pop;

    assign inflight = pend_q || wait_q;
    assign occ      = cnt_q + rd_pkg::FQ_CNT_W'(inflight);
    assign req_fire = req_valid_o && req_ready_i;
    assign rsp_fire = rsp_valid_i && rsp_ready_o;

    // a free slot is reserved for every read that goes out
    assign issue = active_q && !redirect_valid_i && !inflight
                   && (occ < rd_pkg::FQ_CNT_W'(rd_pkg::FQ_DEPTH));

    assign push = rsp_fire && !stale_q && !redirect_valid_i;  // stale answers dropped
    assign pop  = instr_valid_o && instr_ready_i;

    assign req_valid_o = pend_q;
    assign req_o.addr  = req_addr_q;
    assign req_o.size  = rd_pkg::SZ_DWORD;
    assign rsp_ready_o = 1'b1;     // slot already reserved

    assign instr_valid_o = (cnt_q != '0);
    assign instr_o       = fifo_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active_q <= 1'b0;
            pend_q   <= 1'b0;
            wait_q   <= 1'b0;
            stale_q  <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (req_fire) begin
                pend_q <= 1'b0;
                wait_q <= 1'b1;
            end else if (issue) begin
                pend_q <= 1'b1;
            end
            if (rsp_fire) begin
                wait_q  <= 1'b0;
                stale_q <= 1'b0;        // outstanding read finished
            end else if (redirect_valid_i && inflight) begin
                stale_q <= 1'b1;
            end
            if (redirect_valid_i) begin
                active_q <= 1'b1;
                wr_ptr_q <= '0;         // flush queue at once
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
                if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
                cnt_q <= cnt_q + rd_pkg::FQ_CNT_W'(push) - rd_pkg::FQ_CNT_W'(pop);
            end
        end
    end

    // pc and payload
    always_ff @(posedge clk) begin
        if (redirect_valid_i) begin
            pc_q <= {redirect_pc_i[rd_pkg::ADDR_W-1:3], 3'b000};  // align down to 8
        end else if (issue) begin
            pc_q <= pc_q + rd_pkg::ADDR_W'(8);
        end
        if (issue) req_addr_q <= pc_q;
        if (push) begin
            fifo_q[wr_ptr_q].pc   <= req_addr_q;
            fifo_q[wr_ptr_q].data <= rsp_i.data;
        end
    end

endmodule

// File: source/load_unit.sv
`timescale 1ns/1ns

module load_unit (
    input  logic                      clk,
    input  logic                      rst_i,

    input  logic                      ld_valid_i,
    output logic                      ld_ready_o,
    input  rd_pkg::load_cmd_t         ld_cmd_i,

    output logic                      req_valid_o,
    input  logic                      req_ready_i,
    output rd_pkg::rd_req_t           req_o,
    input  logic                      rsp_valid_i,
    output logic                      rsp_ready_o,
    input  rd_pkg::rd_rsp_t           rsp_i,

    output logic                      ld_done_valid_o,
    input  logic                      ld_done_ready_i,
    output logic [rd_pkg::DATA_W-1:0] ld_data_o
);

    typedef enum logic [1:0] {
        LD_IDLE = 2'd0,
        LD_REQ  = 2'd1,   // request on the port
        LD_WAIT = 2'd2,   // waiting for memory data
        LD_DONE = 2'd3    // result held until taken
    } ld_state_e;

    ld_state_e                 state_q;
    rd_pkg::load_cmd_t         cmd_q;
    logic [rd_pkg::DATA_W-1:0] data_q;
    logic [rd_pkg::DATA_W-1:0] shifted;
    logic [rd_pkg::DATA_W-1:0] ext;

    assign ld_ready_o      = (state_q == LD_IDLE);
    assign req_valid_o     = (state_q == LD_REQ);
    assign rsp_ready_o     = (state_q == LD_WAIT);
    assign ld_done_valid_o = (state_q == LD_DONE);
    assign ld_data_o       = data_q;

    assign req_o.addr = {cmd_q.addr[rd_pkg::ADDR_W-1:3], 3'b000};  // whole doubleword
    assign req_o.size = rd_pkg::SZ_DWORD;

    // byte select and extension
    always_comb begin
        shifted = rsp_i.data >> {cmd_q.addr[2:0], 3'b000};
        case (cmd_q.size)
            rd_pkg::SZ_BYTE: begin
                ext = {{56{cmd_q.is_signed && shifted[7]}}, shifted[7:0]};
            end
            rd_pkg::SZ_HALF: begin
                ext = {{48{cmd_q.is_signed && shifted[15]}}, shifted[15:0]};
            end
            rd_pkg::SZ_WORD: begin
                ext = {{32{cmd_q.is_signed && shifted[31]}}, shifted[31:0]};
            end
            default: ext = shifted;     // full dword, nothing to extend
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= LD_IDLE;
        end else begin
            case (state_q)
                LD_IDLE: if (ld_valid_i)                  state_q <= LD_REQ;
                LD_REQ:  if (req_ready_i)                 state_q <= LD_WAIT;
                LD_WAIT: if (rsp_valid_i)                 state_q <= LD_DONE;
                LD_DONE: if (ld_done_ready_i)             state_q <= LD_IDLE;
                default:                                  state_q <= LD_IDLE;
            endcase
        end
    end

    // command and result
    always_ff @(posedge clk) begin
        if (ld_valid_i && ld_ready_o) begin
            cmd_q <= ld_cmd_i;
        end
        if (rsp_valid_i && rsp_ready_o) begin
            data_q <= ext;
        end
    end

endmodule

// File: source/rd_memory.sv
`timescale 1ns/1ns

module rd_memory (
    input  logic            clk,
    input  logic            rst_i,

    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  rd_pkg::rd_req_t req_i,     // size ignored, reads are whole dwords

    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output rd_pkg::rd_rsp_t rsp_o
);

    logic [rd_pkg::DATA_W-1:0]    mem_q [rd_pkg::MEM_WORDS];

    logic                         busy_q;
    logic [rd_pkg::LAT_CNT_W-1:0] cnt_q;    // cycles left until data
    logic [rd_pkg::MEM_IDX_W-1:0] idx_q;
    logic                         req_fire;
    logic                         rsp_fire;

    initial begin
        $readmemh("mem_init.hex", mem_q);
    end

    assign req_ready_o = !busy_q;
    assign rsp_valid_o = busy_q && (cnt_q == '0);
    assign rsp_o.data  = mem_q[idx_q];

    assign req_fire = req_valid_i && req_ready_o;
    assign rsp_fire = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (req_fire) begin
            busy_q <= 1'b1;
            cnt_q  <= rd_pkg::LAT_CNT_W'(rd_pkg::MEM_LATENCY - 1);
        end else if (rsp_fire) begin
            busy_q <= 1'b0;
        end else if (busy_q && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // wrap on addr[7:3]
    always_ff @(posedge clk) begin
        if (req_fire) begin
            idx_q <= req_i.addr[3 +: rd_pkg::MEM_IDX_W];
        end
    end

endmodule

// File: source/rd_subsystem.sv
`timescale 1ns/1ns

module rd_subsystem (
    input  logic                      clk,
    input  logic                      rst_i,

    input  logic                      redirect_valid_i,
    input  logic [rd_pkg::ADDR_W-1:0] redirect_pc_i,

    output logic                      instr_valid_o,
    input  logic                      instr_ready_i,
    output rd_pkg::fetch_entry_t      instr_o,

    input  logic                      ld_valid_i,
    output logic                      ld_ready_o,
    input  rd_pkg::load_cmd_t         ld_cmd_i,
    output logic                      ld_done_valid_o,
    input  logic                      ld_done_ready_i,
    output logic [rd_pkg::DATA_W-1:0] ld_data_o
);

    // load unit to arbiter
    logic            ld_req_valid;
    logic            ld_req_ready;
    rd_pkg::rd_req_t ld_req;
    logic            ld_rsp_valid;
    logic            ld_rsp_ready;
    rd_pkg::rd_rsp_t ld_rsp;

    // fetch queue to arbiter
    logic            if_req_valid;
    logic            if_req_ready;
    rd_pkg::rd_req_t if_req;
    logic            if_rsp_valid;
    logic            if_rsp_ready;
    rd_pkg::rd_rsp_t if_rsp;

    // arbiter to memory
    logic            m_req_valid;
    logic            m_req_ready;
    rd_pkg::rd_req_t m_req;
    logic            m_rsp_valid;
    logic            m_rsp_ready;
    rd_pkg::rd_rsp_t m_rsp;

    fetch_queue i_fetch_queue (
        .clk, .rst_i, .redirect_valid_i, .redirect_pc_i,
        .req_valid_o (if_req_valid), .req_ready_i (if_req_ready), .req_o (if_req),
        .rsp_valid_i (if_rsp_valid), .rsp_ready_o (if_rsp_ready), .rsp_i (if_rsp),
        .instr_valid_o, .instr_ready_i, .instr_o
    );

    load_unit i_load_unit (
        .clk, .rst_i, .ld_valid_i, .ld_ready_o, .ld_cmd_i,
        .req_valid_o (ld_req_valid), .req_ready_i (ld_req_ready), .req_o (ld_req),
        .rsp_valid_i (ld_rsp_valid), .rsp_ready_o (ld_rsp_ready), .rsp_i (ld_rsp),
        .ld_done_valid_o, .ld_done_ready_i, .ld_data_o
    );

    rd_arbiter i_rd_arbiter (
        .clk, .rst_i,
        .ld_req_valid_i (ld_req_valid), .ld_req_ready_o (ld_req_ready), .ld_req_i (ld_req),
        .ld_rsp_valid_o (ld_rsp_valid), .ld_rsp_ready_i (ld_rsp_ready), .ld_rsp_o (ld_rsp),
        .if_req_valid_i (if_req_valid), .if_req_ready_o (if_req_ready), .if_req_i (if_req),
        .if_rsp_valid_o (if_rsp_valid), .if_rsp_ready_i (if_rsp_ready), .if_rsp_o (if_rsp),
        .m_req_valid_o  (m_req_valid),  .m_req_ready_i  (m_req_ready),  .m_req_o  (m_req),
        .m_rsp_valid_i  (m_rsp_valid),  .m_rsp_ready_o  (m_rsp_ready),  .m_rsp_i  (m_rsp)
    );

    rd_memory i_rd_memory (
        .clk, .rst_i,
        .req_valid_i (m_req_valid), .req_ready_o (m_req_ready), .req_i (m_req),
        .rsp_valid_o (m_rsp_valid), .rsp_ready_i (m_rsp_ready), .rsp_o (m_rsp)
    );

endmodule

// File: testbench/tb_rd_subsystem.sv
`timescale 1ns/1ns

module tb_rd_subsystem;

    logic                      clk;
    logic                      rst_i;
    logic                      redirect_valid_i;
    logic [rd_pkg::ADDR_W-1:0] redirect_pc_i;
    logic                      instr_valid_o;
    logic                      instr_ready_i;
    rd_pkg::fetch_entry_t      instr_o;
    logic                      ld_valid_i;
    logic                      ld_ready_o;
    rd_pkg::load_cmd_t         ld_cmd_i;
    logic                      ld_done_valid_o;
    logic                      ld_done_ready_i;
    logic [rd_pkg::DATA_W-1:0] ld_data_o;

    logic [rd_pkg::DATA_W-1:0] model_mem [rd_pkg::MEM_WORDS];  // same wrap on addr[7:3]
    logic [rd_pkg::DATA_W-1:0] ld_exp_q [$];                   // expected load results in order
    logic [rd_pkg::ADDR_W-1:0] exp_pc;                         // next pc of the fetch stream
    string                     test_name;
    int                        error_count;
    int                        loads_checked;
    int                        fetches_checked;
    int                        fetch_taken;      // entries since the last redirect
    int                        waited;
    logic                      ld_cmd_taken;     // command transferred at the last edge
    logic                      prev_iv;
    logic                      prev_itaken;
    logic                      prev_redirect;
    logic                      prev_dv;
    logic                      prev_dtaken;
    rd_pkg::fetch_entry_t      prev_instr;
    logic [rd_pkg::DATA_W-1:0] prev_data;

    rd_subsystem i_rd_subsystem (.*);

    always #20 clk = ~clk;

    task automatic check_equal(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            error_count++;
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // byte-wise pick of the addressed field, then fill of the upper bytes
    function automatic logic [63:0] expected_load(input logic [63:0] word, input logic [2:0] off,
                                                  input rd_pkg::rd_size_e size, input logic sgn);
        logic [63:0] r;
        int          nbytes;
        int          i;
        nbytes = 1 << int'(size);
        r = '0;
        for (i = 0; i < nbytes; i++) begin
            r[8*i +: 8] = word[8*(int'(off) + i) +: 8];
        end
        if (sgn && r[8*nbytes-1]) begin
            for (i = nbytes; i < 8; i++) r[8*i +: 8] = 8'hff;   // negative value
        end
        return r;
    endfunction

    function automatic rd_pkg::load_cmd_t random_load_cmd();
        rd_pkg::load_cmd_t cmd;
        cmd.size      = rd_pkg::rd_size_e'($urandom % 4);
        cmd.is_signed = $urandom % 2;
        cmd.addr      = $urandom & ~((32'd1 << cmd.size) - 32'd1);  // aligned to size
        return cmd;
    endfunction

    // ready mode 0 holds low, 1 holds high and 2 toggles at random
    task automatic drive_cycle(input int p_redirect, input int p_load,
                               input int ir_mode, input int dr_mode);
        @(posedge clk);
        #2;
        redirect_valid_i = (($urandom % 100) < p_redirect);
        if (redirect_valid_i) redirect_pc_i = $urandom;
        instr_ready_i   = (ir_mode == 2) ? ($urandom % 2) : (ir_mode == 1);
        ld_done_ready_i = (dr_mode == 2) ? ($urandom % 2) : (dr_mode == 1);
        if (redirect_valid_i) instr_ready_i = 1'b0;   // head entry gets flushed here
        if (!ld_valid_i || ld_cmd_taken) begin         // valid holds until taken
            ld_valid_i = (($urandom % 100) < p_load);
            if (ld_valid_i) ld_cmd_i = random_load_cmd();
        end
    endtask

    task automatic run_phase(input string name, input int cycles, input int p_redirect,
                             input int p_load, input int ir_mode, input int dr_mode);
        int n;
        test_name = name;
        repeat (cycles) drive_cycle(p_redirect, p_load, ir_mode, dr_mode);
        n = 0;
        while ((ld_valid_i || ld_exp_q.size() != 0) && n < 200) begin   // drain loads
            drive_cycle(0, 0, 1, 1);
            n++;
        end
        if (ld_valid_i || ld_exp_q.size() != 0) begin
            error_count++;
            $display("timeout: load results still missing at the end of %s", name);
        end
    endtask

    // sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk) begin
        if (rst_i) begin
            ld_cmd_taken = 1'b0;
            prev_iv      = 1'b0;
            prev_dv      = 1'b0;
        end else begin
            if (prev_iv && !prev_itaken && !prev_redirect) begin   // offered, not taken
                check_equal("instr_valid_o held", 64'd1, instr_valid_o);
                check_equal("instr_o.pc held", prev_instr.pc, instr_o.pc);
                check_equal("instr_o.data held", prev_instr.data, instr_o.data);
            end
            if (prev_dv && !prev_dtaken) begin
                check_equal("ld_done_valid_o held", 64'd1, ld_done_valid_o);
                check_equal("ld_data_o held", prev_data, ld_data_o);
            end
            if (redirect_valid_i) begin
                exp_pc      = redirect_pc_i & ~32'h7;
                fetch_taken = 0;
            end else if (instr_valid_o && instr_ready_i) begin
                check_equal("fetch pc", exp_pc, instr_o.pc);
                check_equal("fetch data", model_mem[exp_pc[7:3]], instr_o.data);
                exp_pc = exp_pc + 32'd8;
                fetch_taken++;
                fetches_checked++;
            end
            ld_cmd_taken = ld_valid_i && ld_ready_o;
            if (ld_cmd_taken) begin
                ld_exp_q.push_back(expected_load(model_mem[ld_cmd_i.addr[7:3]],
                                   ld_cmd_i.addr[2:0], ld_cmd_i.size, ld_cmd_i.is_signed));
            end
            if (ld_done_valid_o && ld_done_ready_i) begin
                if (ld_exp_q.size() == 0) begin
                    error_count++;
                    $display("load result appeared with no command outstanding in %s",
                             test_name);
                end else begin
                    check_equal("load data", ld_exp_q.pop_front(), ld_data_o);
                    loads_checked++;
                end
            end
            prev_iv       = instr_valid_o;
            prev_itaken   = instr_valid_o && instr_ready_i;
            prev_redirect = redirect_valid_i;
            prev_instr    = instr_o;
            prev_dv       = ld_done_valid_o;
            prev_dtaken   = ld_done_valid_o && ld_done_ready_i;
            prev_data     = ld_data_o;
        end
    end

    initial begin
        clk              = 1'b0;
        rst_i            = 1'b1;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        ld_valid_i       = 1'b0;
        ld_cmd_i         = '0;
        ld_done_ready_i  = 1'b0;
        error_count      = 0;
        loads_checked    = 0;
        fetches_checked  = 0;
        fetch_taken      = 0;
        exp_pc           = '0;
        void'($urandom(32'hcea5));
        $readmemh("mem_init.hex", model_mem);
        repeat (3) @(posedge clk);
        #2 rst_i = 1'b0;

        test_name = "reset_state";
        @(negedge clk);
        check_equal("instr_valid_o", 64'd0, instr_valid_o);
        check_equal("ld_done_valid_o", 64'd0, ld_done_valid_o);
        check_equal("ld_ready_o", 64'd1, ld_ready_o);

        test_name = "seq_fetch";
        drive_cycle(100, 0, 1, 1);       // single redirect
        waited = 0;
        while (fetch_taken < 16 && waited < 300) begin
            drive_cycle(0, 0, 1, 1);
            waited++;
        end
        if (fetch_taken < 16) begin
            error_count++;
            $display("timeout: sequential fetch delivered only %0d entries", fetch_taken);
        end

        run_phase("load_extract", 300, 0, 60, 0, 1);    // queue full, port free for loads
        run_phase("contention", 300, 0, 40, 1, 1);
        run_phase("redirect_discard", 400, 8, 30, 1, 1);
        run_phase("back_pressure", 600, 5, 40, 2, 2);

        assert (loads_checked > 0 && fetches_checked > 0) else begin
            error_count++;
            $display("no traffic was observed on one of the output streams");
        end
        $display("errors: %0d  loads checked: %0d  fetches checked: %0d",
                 error_count, loads_checked, fetches_checked);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: mem_init.hex
// each line is one 64-bit doubleword in hex
// line n holds the word for addr[7:3] == n
8f3a1c027e55d0b4
13579bdf02468ace
fedcba9876543210
0123456789abcdef
80007fff8000ff7f
7f80807f00ff01fe
c3a5e1f00f1e5a3c
5a5aa5a5c33c3cc3
deadbeefcafef00d
0badc0de1ee7b007
ffffffff00000000
00000000ffffffff
a1b2c3d4e5f60718
91827364554637ab
6e5d4c3b2a190817
f0e1d2c3b4a59687
48c26d19f30e7ab5
b7e15162a8b3c9d0
2f4e6a8c0b1d3f57
e8d7c6b5a4938271
7ffe8001fffe0002
19283746afbecddc
c0ffee00baddecaf
3c0fa5f09e61b28d
d4c3b2a1feedface
8080808080808080
7f7f7f7f7f7f7f7f
55aa33cc0ff0e11e
9e3779b97f4a7c15
61c8864680b583eb
a076bd43e9f2c815
4b1dd00d8badf00d

// File: sim.f
common/rd_pkg.sv
arbiter/rd_arbiter.sv
source/fetch_queue.sv
source/load_unit.sv
source/rd_memory.sv
source/rd_subsystem.sv
testbench/tb_rd_subsystem.sv

// File: Bender.yml
package:
  name: rd_subsystem

sources:
  - files:
      - common/rd_pkg.sv
      - arbiter/rd_arbiter.sv
      - source/fetch_queue.sv
      - source/load_unit.sv
      - source/rd_memory.sv
      - source/rd_subsystem.sv
  - target: test
    files:
      - testbench/tb_rd_subsystem.sv
